// File: Makefile
VERILATOR ?= verilator
TOP ?= tbCore
FILELIST ?= vlog.f
OBJDIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: simulate clean

# Build and run; status follows the search for the pass line
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf $(OBJDIR)

// File: corePkg.sv
`default_nettype none

package corePkg;

	// Datapath and instruction word width
	localparam int dataW = 32;
	// Register number width, 32 registers
	localparam int regAddrW = 5;
	// Default bank depth, 256 words
	localparam int memAddrW = 8;

	//////////////////////////////////////////////////////////////////////
	// Instruction encodings
	//////////////////////////////////////////////////////////////////////

	// Major opcode, bits 31..26
	typedef enum logic [5:0] {
		opRType = 6'd0,
		opBeq   = 6'd4,
		opAddi  = 6'd8,
		opLw    = 6'd35,
		opSw    = 6'd43
	} opcodeT;

	// R-type funct field, bits 5..0
	typedef enum logic [5:0] {
		fnAdd = 6'd32,
		fnSub = 6'd34,
		fnAnd = 6'd36,
		fnOr  = 6'd37,
		fnSlt = 6'd42
	} aluFuncT;

	// Internal ALU operation
	typedef enum logic [2:0] {
		aluAdd = 3'd0,
		aluSub = 3'd1,
		aluAnd = 3'd2,
		aluOr  = 3'd3,
		aluSlt = 3'd4
	} aluOpT;

	// Operand source for execute forwarding
	typedef enum logic [1:0] {
		fwdReg = 2'd0,
		fwdWb  = 2'd1,
		fwdMem = 2'd2
	} fwdSelT;

endpackage

`default_nettype wire

// File: hazardIf.sv
`default_nettype none

interface hazardIf;
	import corePkg::*;

	// Source registers in decode and execute
	logic [regAddrW-1:0] rsD;
	logic [regAddrW-1:0] rtD;
	logic [regAddrW-1:0] rsE;
	logic [regAddrW-1:0] rtE;

	// Destinations further down the pipe
	logic [regAddrW-1:0] writeRegE;
	logic [regAddrW-1:0] writeRegM;
	logic [regAddrW-1:0] writeRegW;

	// Control bits per stage
	logic branchD;
	logic memToRegE;
	logic memToRegM;
	logic regWriteE;
	logic regWriteM;
	logic regWriteW;

	// Back from the hazard unit
	logic stallF;
	logic stallD;
	logic flushE;
	logic forwardAD;
	logic forwardBD;
	fwdSelT forwardAE;
	fwdSelT forwardBE;

	modport pipe (
		output rsD, rtD, rsE, rtE, writeRegE, writeRegM, writeRegW,
		output branchD, memToRegE, memToRegM, regWriteE, regWriteM, regWriteW,
		input stallF, stallD, flushE, forwardAD, forwardBD, forwardAE, forwardBE
	);

	modport hazard (
		input rsD, rtD, rsE, rtE, writeRegE, writeRegM, writeRegW,
		input branchD, memToRegE, memToRegM, regWriteE, regWriteM, regWriteW,
		output stallF, stallD, flushE, forwardAD, forwardBD, forwardAE, forwardBE
	);

endinterface

`default_nettype wire

// File: hazardUnit.sv
`default_nettype none

module hazardUnit (
	hazardIf.hazard haz
);
	import corePkg::*;

	// Load in execute feeds decode
	logic lwStall;
	// Branch source still in flight
	logic branchStall;
	logic aluHitE;
	logic loadHitM;

	// Memory stage wins over write-back
	// r0 never forwarded, its value is fixed
	function automatic fwdSelT fwdSel(
		input logic [regAddrW-1:0] src,
		input logic [regAddrW-1:0] dstM,
		input logic weM,
		input logic [regAddrW-1:0] dstW,
		input logic weW
	);
		if (src != '0 && weM && src == dstM)
			return fwdMem;
		else if (src != '0 && weW && src == dstW)
			return fwdWb;
		else
			return fwdReg;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Forwarding
	//////////////////////////////////////////////////////////////////////

	// Execute operands
	assign haz.forwardAE = fwdSel(haz.rsE, haz.writeRegM, haz.regWriteM,
		haz.writeRegW, haz.regWriteW);
	assign haz.forwardBE = fwdSel(haz.rtE, haz.writeRegM, haz.regWriteM,
		haz.writeRegW, haz.regWriteW);

	// Branch compare in decode, memory stage only
	assign haz.forwardAD = haz.rsD != '0 && haz.regWriteM && haz.rsD == haz.writeRegM;
	assign haz.forwardBD = haz.rtD != '0 && haz.regWriteM && haz.rtD == haz.writeRegM;

	//////////////////////////////////////////////////////////////////////
	// Stalls
	//////////////////////////////////////////////////////////////////////

	// Load result exists only after memory
	assign lwStall = haz.memToRegE && haz.writeRegE != '0
		&& (haz.writeRegE == haz.rsD || haz.writeRegE == haz.rtD);

	// ALU result not yet in memory stage
	assign aluHitE = haz.regWriteE && haz.writeRegE != '0
		&& (haz.writeRegE == haz.rsD || haz.writeRegE == haz.rtD);

	// Load data only forwardable from write-back
	assign loadHitM = haz.memToRegM && haz.writeRegM != '0
		&& (haz.writeRegM == haz.rsD || haz.writeRegM == haz.rtD);

	assign branchStall = haz.branchD && (aluHitE || loadHitM);

	// Hold fetch and decode, bubble into execute
	assign haz.stallF = lwStall || branchStall;
	assign haz.stallD = lwStall || branchStall;
	assign haz.flushE = lwStall || branchStall;

endmodule

`default_nettype wire

// File: memBank.sv
`default_nettype none

module memBank #(
	parameter int addrW = corePkg::memAddrW
) (
	input wire clk,
	input wire arstN,
	input wire wbCyc,
	input wire wbStb,
	input wire wbWe,
	input wire [addrW-1:0] wbAdr,
	input wire [corePkg::dataW-1:0] wbDatW,
	output logic [corePkg::dataW-1:0] wbDatR,
	output logic wbAck,
	input wire coreEn,
	input wire [addrW-1:0] coreAddr,
	output logic [corePkg::dataW-1:0] coreRData,
	input wire coreWe,
	input wire [corePkg::dataW-1:0] coreWData
);
	import corePkg::*;

	logic [dataW-1:0] mem [0:(1 << addrW) - 1];
	// New request, not yet acked
	logic wbReq;

	assign wbReq = wbCyc && wbStb && !wbAck;

	// Classic cycle, single ack per request
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			wbAck <= 1'b0;
		else
			wbAck <= wbReq;
	end

	// Bus write on the acking edge, else core store
	always_ff @(posedge clk)
	begin
		if (wbReq && wbWe)
			mem[wbAdr] <= wbDatW;
		else if (coreEn && coreWe)
			mem[coreAddr] <= coreWData;
	end

	// Address held by master, so valid during ack
	assign wbDatR = mem[wbAdr];
	// Fetch or load, same cycle
	assign coreRData = mem[coreAddr];

	// Bus owns the array only while the core is halted
	assert property (@(posedge clk) disable iff (!arstN) !(coreEn && wbCyc && wbStb))
		else $error("memBank: Wishbone strobe while core port enabled");

endmodule

`default_nettype wire

// File: mipsCore.sv
`default_nettype none

module mipsCore #(
	parameter int addrW = corePkg::memAddrW
) (
	input wire clk,
	input wire arstN,
	input wire run,
	// Instruction memory slave
	input wire imemCyc,
	input wire imemStb,
	input wire imemWe,
	input wire [addrW-1:0] imemAdr,
	input wire [corePkg::dataW-1:0] imemDatW,
	output logic [corePkg::dataW-1:0] imemDatR,
	output logic imemAck,
	// Data memory slave
	input wire dmemCyc,
	input wire dmemStb,
	input wire dmemWe,
	input wire [addrW-1:0] dmemAdr,
	input wire [corePkg::dataW-1:0] dmemDatW,
	output logic [corePkg::dataW-1:0] dmemDatR,
	output logic dmemAck,
	// Write-back trace
	output logic wbValid,
	output logic [corePkg::regAddrW-1:0] wbReg,
	output logic [corePkg::dataW-1:0] wbData
);
	import corePkg::*;

	hazardIf hazBus ();

	// Core side of both banks
	logic [addrW-1:0] imemAddr;
	logic [dataW-1:0] imemData;
	logic [addrW-1:0] dmemAddr;
	logic [dataW-1:0] dmemWData;
	logic dmemStoreWe;
	logic [dataW-1:0] dmemRData;
	// Register file ports
	logic [regAddrW-1:0] rs;
	logic [regAddrW-1:0] rt;
	logic [dataW-1:0] rsData;
	logic [dataW-1:0] rtData;
	logic rdWe;
	logic [regAddrW-1:0] rdAddr;
	logic [dataW-1:0] rdData;

	pipeDatapath #(.addrW(addrW)) pipe0 (
		.clk(clk), .arstN(arstN), .run(run), .haz(hazBus),
		.imemAddr(imemAddr), .imemData(imemData),
		.dmemAddr(dmemAddr), .dmemWData(dmemWData), .dmemWe(dmemStoreWe),
		.dmemRData(dmemRData),
		.rs(rs), .rt(rt), .rsData(rsData), .rtData(rtData),
		.rdWe(rdWe), .rdAddr(rdAddr), .rdData(rdData),
		.wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
	);

	hazardUnit hazard0 (
		.haz(hazBus)
	);

	regFile regs0 (
		.clk(clk), .arstN(arstN), .rs(rs), .rt(rt),
		.rsData(rsData), .rtData(rtData),
		.we(rdWe), .wAddr(rdAddr), .wData(rdData)
	);

	// Program store, core only reads
	memBank #(.addrW(addrW)) imem0 (
		.clk(clk), .arstN(arstN),
		.wbCyc(imemCyc), .wbStb(imemStb), .wbWe(imemWe), .wbAdr(imemAdr),
		.wbDatW(imemDatW), .wbDatR(imemDatR), .wbAck(imemAck),
		.coreEn(run), .coreAddr(imemAddr), .coreRData(imemData),
		.coreWe(1'b0), .coreWData('0)
	);

	memBank #(.addrW(addrW)) dmem0 (
		.clk(clk), .arstN(arstN),
		.wbCyc(dmemCyc), .wbStb(dmemStb), .wbWe(dmemWe), .wbAdr(dmemAdr),
		.wbDatW(dmemDatW), .wbDatR(dmemDatR), .wbAck(dmemAck),
		.coreEn(run), .coreAddr(dmemAddr), .coreRData(dmemRData),
		.coreWe(dmemStoreWe), .coreWData(dmemWData)
	);

endmodule

`default_nettype wire

// File: pipeDatapath.sv
`default_nettype none

module pipeDatapath #(
	parameter int addrW = corePkg::memAddrW
) (
	input wire clk,
	input wire arstN,
	input wire run,
	hazardIf.pipe haz,
	output logic [addrW-1:0] imemAddr,
	input wire [corePkg::dataW-1:0] imemData,
	output logic [addrW-1:0] dmemAddr,
	output logic [corePkg::dataW-1:0] dmemWData,
	output logic dmemWe,
	input wire [corePkg::dataW-1:0] dmemRData,
	output logic [corePkg::regAddrW-1:0] rs,
	output logic [corePkg::regAddrW-1:0] rt,
	input wire [corePkg::dataW-1:0] rsData,
	input wire [corePkg::dataW-1:0] rtData,
	output logic rdWe,
	output logic [corePkg::regAddrW-1:0] rdAddr,
	output logic [corePkg::dataW-1:0] rdData,
	output logic wbValid,
	output logic [corePkg::regAddrW-1:0] wbReg,
	output logic [corePkg::dataW-1:0] wbData
);
	import corePkg::*;

	// Fetch
	logic [dataW-1:0] pcF;
	logic [dataW-1:0] pcPlus4F;
	// Decode
	logic validD;
	logic [dataW-1:0] instrD;
	logic [dataW-1:0] pcPlus4D;
	opcodeT opD;
	aluFuncT functD;
	logic [regAddrW-1:0] rsD;
	logic [regAddrW-1:0] rtD;
	logic [regAddrW-1:0] rdD;
	logic [regAddrW-1:0] writeRegD;
	logic [dataW-1:0] immD;
	logic regWriteD;
	logic memToRegD;
	logic memWriteD;
	logic branchD;
	logic aluSrcD;
	logic regDstD;
	aluOpT aluOpD;
	logic [dataW-1:0] cmpAD;
	logic [dataW-1:0] cmpBD;
	logic pcSrcD;
	logic [dataW-1:0] pcBranchD;
	// Execute
	logic regWriteE;
	logic memToRegE;
	logic memWriteE;
	logic aluSrcE;
	aluOpT aluOpE;
	logic [regAddrW-1:0] rsE;
	logic [regAddrW-1:0] rtE;
	logic [regAddrW-1:0] writeRegE;
	logic [dataW-1:0] rsDataE;
	logic [dataW-1:0] rtDataE;
	logic [dataW-1:0] immE;
	logic [dataW-1:0] srcAE;
	logic [dataW-1:0] srcBE;
	logic [dataW-1:0] writeDataE;
	logic [dataW-1:0] aluOutE;
	// Memory
	logic regWriteM;
	logic memToRegM;
	logic memWriteM;
	logic [regAddrW-1:0] writeRegM;
	logic [dataW-1:0] aluOutM;
	logic [dataW-1:0] writeDataM;
	// Write-back
	logic regWriteW;
	logic memToRegW;
	logic [regAddrW-1:0] writeRegW;
	logic [dataW-1:0] aluOutW;
	logic [dataW-1:0] readDataW;
	logic [dataW-1:0] resultW;

	//////////////////////////////////////////////////////////////////////
	// Fetch
	//////////////////////////////////////////////////////////////////////

	assign pcPlus4F = pcF + 32'd4;
	// Byte pc, word-addressed bank
	assign imemAddr = pcF[addrW+1:2];

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			pcF <= '0;
		else if (!run)
			pcF <= '0;
		else if (!haz.stallF)
			pcF <= pcSrcD ? pcBranchD : pcPlus4F;
	end

	// Taken branch squashes the slot behind it
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			validD <= 1'b0;
		else if (!run)
			validD <= 1'b0;
		else if (!haz.stallD)
			validD <= !pcSrcD;
	end

	always_ff @(posedge clk)
	begin
		if (!haz.stallD)
		begin
			instrD <= imemData;
			pcPlus4D <= pcPlus4F;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Decode
	//////////////////////////////////////////////////////////////////////

	assign opD = opcodeT'(instrD[31:26]);
	assign functD = aluFuncT'(instrD[5:0]);
	assign rsD = instrD[25:21];
	assign rtD = instrD[20:16];
	assign rdD = instrD[15:11];
	assign immD = {{16{instrD[15]}}, instrD[15:0]};

	// Control, all zero for an empty slot
	always_comb
	begin
		regWriteD = 1'b0;
		memToRegD = 1'b0;
		memWriteD = 1'b0;
		branchD = 1'b0;
		aluSrcD = 1'b0;
		regDstD = 1'b0;
		aluOpD = aluAdd;
		if (validD)
		begin
			case (opD)
				opRType:
				begin
					regWriteD = 1'b1;
					regDstD = 1'b1;
					case (functD)
						fnSub: aluOpD = aluSub;
						fnAnd: aluOpD = aluAnd;
						fnOr: aluOpD = aluOr;
						fnSlt: aluOpD = aluSlt;
						default: aluOpD = aluAdd;
					endcase
				end
				opAddi:
				begin
					regWriteD = 1'b1;
					aluSrcD = 1'b1;
				end
				opLw:
				begin
					regWriteD = 1'b1;
					memToRegD = 1'b1;
					aluSrcD = 1'b1;
				end
				opSw:
				begin
					memWriteD = 1'b1;
					aluSrcD = 1'b1;
				end
				opBeq: branchD = 1'b1;
				default: regWriteD = 1'b0;
			endcase
		end
		writeRegD = regDstD ? rdD : rtD;
		// Writes to r0 dropped here, nop included
		if (writeRegD == '0)
			regWriteD = 1'b0;
	end

	assign rs = rsD;
	assign rt = rtD;

	// Equality compare, operands from memory stage if newer
	assign cmpAD = haz.forwardAD ? aluOutM : rsData;
	assign cmpBD = haz.forwardBD ? aluOutM : rtData;
	// No decision while the compare waits on a stall
	assign pcSrcD = branchD && cmpAD == cmpBD && !haz.stallD;
	assign pcBranchD = pcPlus4D + {immD[dataW-3:0], 2'b00};

	//////////////////////////////////////////////////////////////////////
	// Execute
	//////////////////////////////////////////////////////////////////////

	// Flush leaves a bubble
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			regWriteE <= 1'b0;
			memToRegE <= 1'b0;
			memWriteE <= 1'b0;
		end
		else if (!run || haz.flushE)
		begin
			regWriteE <= 1'b0;
			memToRegE <= 1'b0;
			memWriteE <= 1'b0;
		end
		else
		begin
			regWriteE <= regWriteD;
			memToRegE <= memToRegD;
			memWriteE <= memWriteD;
		end
	end

	always_ff @(posedge clk)
	begin
		aluOpE <= aluOpD;
		aluSrcE <= aluSrcD;
		rsE <= rsD;
		rtE <= rtD;
		writeRegE <= writeRegD;
		rsDataE <= rsData;
		rtDataE <= rtData;
		immE <= immD;
	end

	// Operand muxes
	always_comb
	begin
		case (haz.forwardAE)
			fwdMem: srcAE = aluOutM;
			fwdWb: srcAE = resultW;
			default: srcAE = rsDataE;
		endcase
		case (haz.forwardBE)
			fwdMem: writeDataE = aluOutM;
			fwdWb: writeDataE = resultW;
			default: writeDataE = rtDataE;
		endcase
	end

	assign srcBE = aluSrcE ? immE : writeDataE;

	// ALU
	always_comb
	begin
		case (aluOpE)
			aluSub: aluOutE = srcAE - srcBE;
			aluAnd: aluOutE = srcAE & srcBE;
			aluOr: aluOutE = srcAE | srcBE;
			aluSlt: aluOutE = {31'd0, $signed(srcAE) < $signed(srcBE)};
			default: aluOutE = srcAE + srcBE;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Memory and write-back
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			regWriteM <= 1'b0;
			memToRegM <= 1'b0;
			memWriteM <= 1'b0;
			regWriteW <= 1'b0;
			memToRegW <= 1'b0;
		end
		else if (!run)
		begin
			regWriteM <= 1'b0;
			memToRegM <= 1'b0;
			memWriteM <= 1'b0;
			regWriteW <= 1'b0;
			memToRegW <= 1'b0;
		end
		else
		begin
			regWriteM <= regWriteE;
			memToRegM <= memToRegE;
			memWriteM <= memWriteE;
			regWriteW <= regWriteM;
			memToRegW <= memToRegM;
		end
	end

	always_ff @(posedge clk)
	begin
		writeRegM <= writeRegE;
		aluOutM <= aluOutE;
		writeDataM <= writeDataE;
		writeRegW <= writeRegM;
		aluOutW <= aluOutM;
		readDataW <= dmemRData;
	end

	// Byte address to word index
	assign dmemAddr = aluOutM[addrW+1:2];
	assign dmemWData = writeDataM;
	assign dmemWe = memWriteM;

	assign resultW = memToRegW ? readDataW : aluOutW;
	assign rdWe = regWriteW;
	assign rdAddr = writeRegW;
	assign rdData = resultW;

	// Hazard unit view
	assign haz.rsD = rsD;
	assign haz.rtD = rtD;
	assign haz.rsE = rsE;
	assign haz.rtE = rtE;
	assign haz.writeRegE = writeRegE;
	assign haz.writeRegM = writeRegM;
	assign haz.writeRegW = writeRegW;
	assign haz.branchD = branchD;
	assign haz.memToRegE = memToRegE;
	assign haz.memToRegM = memToRegM;
	assign haz.regWriteE = regWriteE;
	assign haz.regWriteM = regWriteM;
	assign haz.regWriteW = regWriteW;

	// Trace, one cycle after the register file write
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			wbValid <= 1'b0;
		else
			wbValid <= regWriteW;
	end

	always_ff @(posedge clk)
	begin
		wbReg <= writeRegW;
		wbData <= resultW;
	end

	// r0 writes filtered in decode, must never reach the trace
	assert property (@(posedge clk) disable iff (!arstN) wbValid |-> wbReg != '0)
		else $error("pipeDatapath: trace reports a write to r0");

endmodule

`default_nettype wire

// File: regFile.sv
`default_nettype none

module regFile (
	input wire clk,
	input wire arstN,
	input wire [corePkg::regAddrW-1:0] rs,
	input wire [corePkg::regAddrW-1:0] rt,
	output logic [corePkg::dataW-1:0] rsData,
	output logic [corePkg::dataW-1:0] rtData,
	input wire we,
	input wire [corePkg::regAddrW-1:0] wAddr,
	input wire [corePkg::dataW-1:0] wData
);
	import corePkg::*;

	// No storage behind register 0
	logic [dataW-1:0] regs [1:31];

	// One read port, zero for r0, bypass on a same-cycle write
	function automatic logic [dataW-1:0] readPort(input logic [regAddrW-1:0] addr);
		if (addr == '0)
			return '0;
		else if (we && wAddr == addr)
			return wData;
		else
			return regs[addr];
	endfunction

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			for (int i = 1; i < 32; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (we && wAddr != '0)
		begin
			regs[wAddr] <= wData;
		end
	end

	// Decode reads both sources every cycle
	always_comb
	begin
		rsData = readPort(rs);
		rtData = readPort(rt);
	end

endmodule

`default_nettype wire

// File: tbChecker.sv
`default_nettype none

module tbChecker #(
	parameter int runLimit = 900,
	parameter int quietCycles = 32
) (
	input wire clk,
	input wire run,
	input wire endRun,
	// Instruction memory bus as seen by the slave
	input wire imemCyc,
	input wire imemStb,
	input wire imemWe,
	input wire [corePkg::memAddrW-1:0] imemAdr,
	input wire [corePkg::dataW-1:0] imemDatW,
	input wire [corePkg::dataW-1:0] imemDatR,
	input wire imemAck,
	// Data memory bus
	input wire dmemCyc,
	input wire dmemStb,
	input wire dmemWe,
	input wire [corePkg::memAddrW-1:0] dmemAdr,
	input wire [corePkg::dataW-1:0] dmemDatW,
	input wire [corePkg::dataW-1:0] dmemDatR,
	input wire dmemAck,
	// Write-back trace
	input wire wbValid,
	input wire [corePkg::regAddrW-1:0] wbReg,
	input wire [corePkg::dataW-1:0] wbData,
	output logic quiet,
	output logic timedOut,
	output int traceErrors,
	output int memErrors,
	output int busErrors
);
	import corePkg::*;

	localparam int depth = 1 << memAddrW;

	// Every word written over Wishbone
	logic [dataW-1:0] iShadow [0:depth-1];
	logic [dataW-1:0] dShadow [0:depth-1];
	// Instruction-set model state
	logic [dataW-1:0] modelMem [0:depth-1];
	logic [dataW-1:0] modelRegs [0:31];
	// Expected register writes in order
	logic [regAddrW+dataW-1:0] expQ [$];
	logic ran;
	logic runPrev;
	logic endSeen;
	int idleCycles;
	int runCycles;
	// Per bus state, 0 imem and 1 dmem
	logic reqPrev [0:1];
	logic ackPrev [0:1];
	int reqStarts [0:1];
	int ackCount [0:1];

	initial
	begin
		ran = 1'b0;
		runPrev = 1'b0;
		endSeen = 1'b0;
		timedOut = 1'b0;
		idleCycles = 0;
		runCycles = 0;
		traceErrors = 0;
		memErrors = 0;
		busErrors = 0;
		for (int b = 0; b < 2; b++)
		begin
			reqPrev[b] = 1'b0;
			ackPrev[b] = 1'b0;
			reqStarts[b] = 0;
			ackCount[b] = 0;
		end
	end

	assign quiet = run && idleCycles >= quietCycles;

	//////////////////////////////////////////////////////////////////////
	// Instruction-set model
	//////////////////////////////////////////////////////////////////////

	// Register write as the architecture sees it
	task automatic modelWrite(input logic [regAddrW-1:0] r, input logic [dataW-1:0] v);
		if (r != '0)
		begin
			modelRegs[r] = v;
			expQ.push_back({r, v});
		end
	endtask

	// Runs the loaded program up to its final self loop
	task automatic runModel();
		logic [dataW-1:0] ins;
		logic [dataW-1:0] a;
		logic [dataW-1:0] b;
		logic [dataW-1:0] imm;
		logic [dataW-1:0] ea;
		logic [dataW-1:0] res;
		int pc;
		int steps;
		logic done;
		for (int i = 0; i < 32; i++)
		begin
			modelRegs[i] = '0;
		end
		modelMem = dShadow;
		expQ.delete();
		pc = 0;
		done = 1'b0;
		for (steps = 0; steps < 4096 && !done; steps++)
		begin
			ins = iShadow[pc[memAddrW-1:0]];
			a = modelRegs[ins[25:21]];
			b = modelRegs[ins[20:16]];
			imm = {{16{ins[15]}}, ins[15:0]};
			ea = a + imm;
			pc = pc + 1;
			case (ins[31:26])
				opRType:
				begin
					case (ins[5:0])
						fnSub: res = a - b;
						fnAnd: res = a & b;
						fnOr: res = a | b;
						fnSlt: res = {31'd0, $signed(a) < $signed(b)};
						default: res = a + b;
					endcase
					// nop lands here with rd zero
					modelWrite(ins[15:11], res);
				end
				opAddi: modelWrite(ins[20:16], ea);
				opLw: modelWrite(ins[20:16], modelMem[ea[memAddrW+1:2]]);
				opSw: modelMem[ea[memAddrW+1:2]] = b;
				opBeq:
				begin
					if (a == b)
					begin
						// Offset of minus one is the end loop
						if (imm == '1)
							done = 1'b1;
						pc = pc + $signed(imm);
					end
				end
				default: ;
			endcase
		end
		if (!done)
		begin
			$display("Model never reached the final loop of the program");
			traceErrors++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Monitors
	//////////////////////////////////////////////////////////////////////

	// One ack per request and never two in a row
	task automatic checkBus(input int b, input logic req, input logic ack);
		if (req && !reqPrev[b])
			reqStarts[b]++;
		if (ack && !req)
		begin
			$display("%s bus raised ack with no request pending", b == 0 ? "imem" : "dmem");
			busErrors++;
		end
		if (ack && ackPrev[b])
		begin
			$display("%s bus held ack for more than one cycle", b == 0 ? "imem" : "dmem");
			busErrors++;
		end
		if (ack)
			ackCount[b]++;
		reqPrev[b] = req;
		ackPrev[b] = ack;
	endtask

	// Before run the written word and after run the model
	task automatic checkRead();
		logic [dataW-1:0] expWord;
		expWord = ran ? modelMem[dmemAdr] : dShadow[dmemAdr];
		if (dmemDatR !== expWord)
		begin
			$display("[ERROR] dmemDatR word %0d: expected %h, got %h", dmemAdr, expWord, dmemDatR);
			memErrors++;
		end
	endtask

	task automatic checkTrace();
		logic [regAddrW+dataW-1:0] expWrite;
		if (wbReg == '0)
		begin
			$display("Trace reported a write to register 0");
			traceErrors++;
		end
		if (expQ.size() == 0)
		begin
			$display("Trace wrote r%0d = %h after the last expected write", wbReg, wbData);
			traceErrors++;
		end
		else
		begin
			expWrite = expQ.pop_front();
			if (wbReg !== expWrite[dataW+:regAddrW])
			begin
				$display("[ERROR] wbReg: expected %h, got %h", expWrite[dataW+:regAddrW], wbReg);
				traceErrors++;
			end
			if (wbData !== expWrite[dataW-1:0])
			begin
				$display("[ERROR] wbData: expected %h, got %h", expWrite[dataW-1:0], wbData);
				traceErrors++;
			end
		end
	endtask

	// Mid-cycle sampling, all DUT outputs settled
	always @(negedge clk)
	begin
		checkBus(0, imemCyc && imemStb, imemAck);
		checkBus(1, dmemCyc && dmemStb, dmemAck);
		if (imemAck && imemWe)
			iShadow[imemAdr] = imemDatW;
		if (dmemAck && dmemWe)
			dShadow[dmemAdr] = dmemDatW;
		// Program words read back over the bus
		if (imemAck && !imemWe && imemDatR !== iShadow[imemAdr])
		begin
			$display("[ERROR] imemDatR word %0d: expected %h, got %h", imemAdr,
				iShadow[imemAdr], imemDatR);
			memErrors++;
		end
		if (dmemAck && !dmemWe)
			checkRead();
		// Program and data fixed once the core starts
		if (run && !runPrev)
		begin
			ran = 1'b1;
			runModel();
		end
		runPrev = run;
		if (run)
		begin
			runCycles++;
			idleCycles = wbValid ? 0 : idleCycles + 1;
		end
		else
			idleCycles = 0;
		if (wbValid)
			checkTrace();
		if (run && !timedOut && idleCycles < quietCycles && runCycles >= runLimit)
		begin
			$display("Timeout: trace still active after %0d cycles of run", runCycles);
			timedOut = 1'b1;
			traceErrors++;
		end
		// Leftovers once the testbench is done
		if (endRun && !endSeen)
		begin
			endSeen = 1'b1;
			if (expQ.size() != 0)
			begin
				$display("%0d expected register writes never appeared on the trace", expQ.size());
				traceErrors++;
			end
			for (int b = 0; b < 2; b++)
			begin
				if (reqStarts[b] != ackCount[b])
				begin
					$display("%s bus saw %0d requests but %0d acks", b == 0 ? "imem" : "dmem",
						reqStarts[b], ackCount[b]);
					busErrors++;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: tbCore.sv
`default_nettype none

module tbCore;
	import corePkg::*;

	localparam int progLen = 200;
	localparam int dataWords = 64;
	// Four cycles per instruction plus slack
	localparam int runLimit = progLen * 4 + 100;

	logic clk;
	logic arstN;
	logic run;
	logic endRun;
	logic imemCyc;
	logic imemStb;
	logic imemWe;
	logic [memAddrW-1:0] imemAdr;
	logic [dataW-1:0] imemDatW;
	logic [dataW-1:0] imemDatR;
	logic imemAck;
	logic dmemCyc;
	logic dmemStb;
	logic dmemWe;
	logic [memAddrW-1:0] dmemAdr;
	logic [dataW-1:0] dmemDatW;
	logic [dataW-1:0] dmemDatR;
	logic dmemAck;
	logic wbValid;
	logic [regAddrW-1:0] wbReg;
	logic [dataW-1:0] wbData;
	logic quiet;
	logic timedOut;
	int traceErrors;
	int memErrors;
	int busErrors;
	int ackMissing;
	// Program words plus end loop and one pad
	logic [dataW-1:0] prog [0:progLen+1];

	mipsCore #(.addrW(memAddrW)) dut0 (
		.clk(clk), .arstN(arstN), .run(run),
		.imemCyc(imemCyc), .imemStb(imemStb), .imemWe(imemWe), .imemAdr(imemAdr),
		.imemDatW(imemDatW), .imemDatR(imemDatR), .imemAck(imemAck),
		.dmemCyc(dmemCyc), .dmemStb(dmemStb), .dmemWe(dmemWe), .dmemAdr(dmemAdr),
		.dmemDatW(dmemDatW), .dmemDatR(dmemDatR), .dmemAck(dmemAck),
		.wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
	);

	tbChecker #(.runLimit(runLimit)) check0 (
		.clk(clk), .run(run), .endRun(endRun),
		.imemCyc(imemCyc), .imemStb(imemStb), .imemWe(imemWe), .imemAdr(imemAdr),
		.imemDatW(imemDatW), .imemDatR(imemDatR), .imemAck(imemAck),
		.dmemCyc(dmemCyc), .dmemStb(dmemStb), .dmemWe(dmemWe), .dmemAdr(dmemAdr),
		.dmemDatW(dmemDatW), .dmemDatR(dmemDatR), .dmemAck(dmemAck),
		.wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
		.quiet(quiet), .timedOut(timedOut),
		.traceErrors(traceErrors), .memErrors(memErrors), .busErrors(busErrors)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// Program generation
	//////////////////////////////////////////////////////////////////////

	function automatic logic [dataW-1:0] encR(input aluFuncT fn, input int s, input int t,
		input int d);
		return {6'd0, 5'(s), 5'(t), 5'(d), 5'd0, fn};
	endfunction

	function automatic logic [dataW-1:0] encI(input opcodeT op, input int s, input int t,
		input logic [15:0] imm);
		return {op, 5'(s), 5'(t), imm};
	endfunction

	// Only r1 to r7 so hazards come often
	function automatic int randReg();
		return int'($urandom_range(7, 1));
	endfunction

	task automatic buildProgram();
		int kind;
		int s;
		int t;
		for (int i = 0; i < progLen; i++)
		begin
			kind = int'($urandom_range(9, 0));
			// Branch target must stay inside the program
			if (kind == 8 && i > progLen - 4)
				kind = 9;
			s = randReg();
			// Same source twice often enough for taken branches
			t = $urandom_range(1, 0) == 1 ? s : randReg();
			case (kind)
				0: prog[i] = encR(fnAdd, s, t, randReg());
				1: prog[i] = encR(fnSub, s, t, randReg());
				2: prog[i] = encR(fnAnd, s, t, randReg());
				3: prog[i] = encR(fnOr, s, t, randReg());
				4: prog[i] = encR(fnSlt, s, t, randReg());
				5: prog[i] = encI(opAddi, s, randReg(), 16'($urandom_range(16, 0) - 8));
				6: prog[i] = encI(opLw, 0, t, 16'(4 * $urandom_range(dataWords - 1, 0)));
				7: prog[i] = encI(opSw, 0, t, 16'(4 * $urandom_range(dataWords - 1, 0)));
				8: prog[i] = encI(opBeq, s, t, 16'($urandom_range(3, 1)));
				default: prog[i] = '0;
			endcase
		end
		// End loop branches onto itself
		prog[progLen] = encI(opBeq, 0, 0, 16'hffff);
		prog[progLen + 1] = '0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Wishbone master
	//////////////////////////////////////////////////////////////////////

	// Request held until the edge after ack then idle one cycle
	task automatic wbAccess(input logic toData, input logic write, input int adr,
		input logic [dataW-1:0] dat);
		logic gotAck;
		int waited;
		gotAck = 1'b0;
		waited = 0;
		if (toData)
		begin
			dmemCyc = 1'b1;
			dmemStb = 1'b1;
			dmemWe = write;
			dmemAdr = memAddrW'(adr);
			dmemDatW = dat;
		end
		else
		begin
			imemCyc = 1'b1;
			imemStb = 1'b1;
			imemWe = write;
			imemAdr = memAddrW'(adr);
			imemDatW = dat;
		end
		while (!gotAck && waited < 8)
		begin
			@(posedge clk);
			#1;
			waited++;
			gotAck = toData ? dmemAck : imemAck;
		end
		@(posedge clk);
		#1;
		dmemCyc = 1'b0;
		dmemStb = 1'b0;
		dmemWe = 1'b0;
		imemCyc = 1'b0;
		imemStb = 1'b0;
		imemWe = 1'b0;
		if (!gotAck)
		begin
			$display("%s word %0d got no ack within 8 cycles", toData ? "dmem" : "imem", adr);
			ackMissing++;
		end
		@(posedge clk);
		#1;
	endtask

	initial
	begin : stimulus
		void'($urandom(32'h86d65c55));
		arstN = 1'b0;
		run = 1'b0;
		endRun = 1'b0;
		ackMissing = 0;
		imemCyc = 1'b0;
		imemStb = 1'b0;
		imemWe = 1'b0;
		imemAdr = '0;
		imemDatW = '0;
		dmemCyc = 1'b0;
		dmemStb = 1'b0;
		dmemWe = 1'b0;
		dmemAdr = '0;
		dmemDatW = '0;
		repeat (8) @(posedge clk);
		#1;
		arstN = 1'b1;
		buildProgram();
		for (int i = 0; i <= progLen + 1; i++)
			wbAccess(1'b0, 1'b1, i, prog[i]);
		// Program read back through the instruction port
		for (int i = 0; i <= progLen + 1; i++)
			wbAccess(1'b0, 1'b0, i, '0);
		for (int i = 0; i < dataWords; i++)
			wbAccess(1'b1, 1'b1, i, $urandom());
		// Read back before the core touches memory
		for (int i = 0; i < dataWords; i++)
			wbAccess(1'b1, 1'b0, i, '0);
		run = 1'b1;
		// Checker decides quiet or timeout
		while (!quiet && !timedOut)
			@(posedge clk);
		#1;
		run = 1'b0;
		if (!timedOut)
		begin
			for (int i = 0; i < dataWords; i++)
				wbAccess(1'b1, 1'b0, i, '0);
		end
		endRun = 1'b1;
		@(posedge clk);
		#1;
		$display("Errors: trace %0d, memory %0d, bus %0d, missing acks %0d",
			traceErrors, memErrors, busErrors, ackMissing);
		if (traceErrors + memErrors + busErrors + ackMissing == 0 && !timedOut)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
corePkg.sv
hazardIf.sv
regFile.sv
hazardUnit.sv
memBank.sv
pipeDatapath.sv
mipsCore.sv
tbChecker.sv
tbCore.sv
